// ==== reg_engine_pkg.sv ====
package reg_engine_pkg;

	//////////////////////////////
	// Datapath sizes
	//////////////////////////////

	localparam int data_width = 16;
	localparam int reg_count = 16;
	localparam int reg_addr_width = 4;
	localparam int instr_width = 16;

	// Shift amount comes from the low bits of rs2
	localparam int shift_width = 4;

	//////////////////////////////
	// Instruction format
	//////////////////////////////

	localparam int opcode_msb = 15;
	localparam int opcode_lsb = 12;
	localparam int rd_msb = 11;
	localparam int rd_lsb = 8;
	localparam int rs1_msb = 7;
	localparam int rs1_lsb = 4;
	localparam int rs2_msb = 3;
	localparam int rs2_lsb = 0;
	// LDI immediate overlays rs1 and rs2
	localparam int imm_msb = 7;
	localparam int imm_lsb = 0;

	// Codes not listed here behave as NOP
	typedef enum logic [3:0] {
		op_nop = 4'h0,
		op_add = 4'h1,
		op_sub = 4'h2,
		op_and = 4'h3,
		op_or  = 4'h4,
		op_xor = 4'h5,
		op_shl = 4'h6,
		op_shr = 4'h7,
		op_ldi = 4'h8,
		op_out = 4'h9
	} opcode_e;

	//////////////////////////////
	// Queues and host bus
	//////////////////////////////

	localparam int cmd_fifo_depth = 8;
	localparam int res_fifo_depth = 8;
	localparam int level_width = 4;

	localparam int axi_addr_width = 4;
	localparam int axi_data_width = 32;
	localparam int axi_strb_width = axi_data_width / 8;

	localparam logic [axi_addr_width-1:0] addr_cmd = 4'h0;
	localparam logic [axi_addr_width-1:0] addr_result = 4'h4;
	localparam logic [axi_addr_width-1:0] addr_status = 4'h8;

	// Level fields inside the status word
	localparam int status_cmd_lsb = 0;
	localparam int status_res_lsb = 8;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      write,
	input  logic [reg_engine_pkg::reg_addr_width-1:0] write_select,
	input  logic [reg_engine_pkg::reg_addr_width-1:0] read_select_1,
	input  logic [reg_engine_pkg::reg_addr_width-1:0] read_select_2,
	input  logic [reg_engine_pkg::data_width-1:0]     write_data,
	output logic [reg_engine_pkg::data_width-1:0]     read_data_1,
	output logic [reg_engine_pkg::data_width-1:0]     read_data_2
);

	logic [reg_engine_pkg::data_width-1:0] regs [reg_engine_pkg::reg_count];

	// Whole array clears on reset
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < reg_engine_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[write_select] <= write_data;
		end
	end

	// Read ports, no bypass of a same-cycle write
	always_comb begin
		read_data_1 = regs[read_select_1];
		read_data_2 = regs[read_select_2];
	end

	a_write_select_known: assert property (
		@(posedge clk) disable iff (!reset)
		write |-> !$isunknown(write_select)
	) else $error("regfile write with unknown select");

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter int width = reg_engine_pkg::data_width,
	parameter int depth = 8
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         push_valid,
	input  logic [width-1:0]             push_data,
	output logic                         push_ready,
	output logic                         pop_valid,
	output logic [width-1:0]             pop_data,
	input  logic                         pop,
	output logic [$clog2(depth+1)-1:0]   level
);

	logic [width-1:0]           mem [depth];
	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth)-1:0]   rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	assign push_ready = (count != depth);
	assign pop_valid = (count != 0);
	// Show-ahead head
	assign pop_data = mem[rd_ptr];
	assign level = count;

	assign do_push = push_valid && push_ready;
	assign do_pop = pop && pop_valid;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// A push refused while full stays offered with the same data
	a_push_held_when_full: assert property (
		@(posedge clk) disable iff (!reset)
		push_valid && !push_ready |=> push_valid && $stable(push_data)
	) else $error("sync_fifo push withdrawn or changed while full");

	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!reset)
		pop |-> pop_valid
	) else $error("sync_fifo popped while empty");

endmodule

// ==== axil_cmd_port.sv ====
`timescale 1ns/1ps

module axil_cmd_port (
	input  logic                                      clk,
	input  logic                                      reset,
	// AXI4-Lite write address and data
	input  logic [reg_engine_pkg::axi_addr_width-1:0] awaddr,
	input  logic                                      awvalid,
	output logic                                      awready,
	input  logic [reg_engine_pkg::axi_data_width-1:0] wdata,
	input  logic [reg_engine_pkg::axi_strb_width-1:0] wstrb,
	input  logic                                      wvalid,
	output logic                                      wready,
	// AXI4-Lite write response
	output logic [1:0]                                bresp,
	output logic                                      bvalid,
	input  logic                                      bready,
	// AXI4-Lite read
	input  logic [reg_engine_pkg::axi_addr_width-1:0] araddr,
	input  logic                                      arvalid,
	output logic                                      arready,
	output logic [reg_engine_pkg::axi_data_width-1:0] rdata,
	output logic [1:0]                                rresp,
	output logic                                      rvalid,
	input  logic                                      rready,
	// Command queue push side
	output logic                                      cmd_push_valid,
	output logic [reg_engine_pkg::instr_width-1:0]    cmd_push_data,
	input  logic                                      cmd_push_ready,
	// Result queue pop side
	input  logic                                      res_valid,
	input  logic [reg_engine_pkg::data_width-1:0]     res_data,
	output logic                                      res_pop,
	// Queue levels for status
	input  logic [reg_engine_pkg::level_width-1:0]    cmd_level,
	input  logic [reg_engine_pkg::level_width-1:0]    res_level
);

	logic                                      wr_is_cmd;
	logic                                      write_accept;
	logic                                      read_accept;
	logic [reg_engine_pkg::axi_data_width-1:0] status_word;

	//////////////////////////////
	// Write channel
	//////////////////////////////

	assign wr_is_cmd = (awaddr == reg_engine_pkg::addr_cmd);

	// Address and data taken together, cmd writes wait for queue space
	assign write_accept = awvalid && wvalid && !bvalid && (!wr_is_cmd || cmd_push_ready);

	assign awready = write_accept;
	assign wready = write_accept;

	// Byte strobes play no part, every write is a full instruction word
	assign cmd_push_valid = write_accept && wr_is_cmd;
	assign cmd_push_data = wdata[reg_engine_pkg::instr_width-1:0];

	always_ff @(posedge clk) begin
		if (!reset) begin
			bvalid <= 1'b0;
		end else if (write_accept) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (write_accept) begin
			bresp <= wr_is_cmd ? reg_engine_pkg::resp_okay : reg_engine_pkg::resp_slverr;
		end
	end

	//////////////////////////////
	// Read channel
	//////////////////////////////

	assign read_accept = arvalid && !rvalid;
	assign arready = read_accept;

	// Result head leaves the queue in the accept cycle
	assign res_pop = read_accept && (araddr == reg_engine_pkg::addr_result) && res_valid;

	always_comb begin
		status_word = '0;
		status_word[reg_engine_pkg::status_cmd_lsb +: reg_engine_pkg::level_width] = cmd_level;
		status_word[reg_engine_pkg::status_res_lsb +: reg_engine_pkg::level_width] = res_level;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			rvalid <= 1'b0;
		end else if (read_accept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (read_accept) begin
			case (araddr)
				reg_engine_pkg::addr_result: begin
					if (res_valid) begin
						rdata <= reg_engine_pkg::axi_data_width'(res_data);
						rresp <= reg_engine_pkg::resp_okay;
					end else begin
						rdata <= '0;
						rresp <= reg_engine_pkg::resp_slverr;
					end
				end
				reg_engine_pkg::addr_status: begin
					rdata <= status_word;
					rresp <= reg_engine_pkg::resp_okay;
				end
				default: begin
					rdata <= '0;
					rresp <= reg_engine_pkg::resp_slverr;
				end
			endcase
		end
	end

	a_b_hold: assert property (
		@(posedge clk) disable iff (!reset)
		bvalid && !bready |=> bvalid && $stable(bresp)
	) else $error("write response dropped or changed before bready");

	a_r_hold: assert property (
		@(posedge clk) disable iff (!reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata)
	) else $error("read response dropped or changed before rready");

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
	input  logic                                   clk,
	input  logic                                   reset,
	// Command queue head
	input  logic                                   cmd_valid,
	input  logic [reg_engine_pkg::instr_width-1:0] cmd_data,
	output logic                                   cmd_pop,
	// Result queue push side
	output logic                                   res_push_valid,
	output logic [reg_engine_pkg::data_width-1:0]  res_push_data,
	input  logic                                   res_push_ready
);

	reg_engine_pkg::opcode_e                  opcode;
	logic [reg_engine_pkg::reg_addr_width-1:0] rd;
	logic [reg_engine_pkg::reg_addr_width-1:0] rs1;
	logic [reg_engine_pkg::reg_addr_width-1:0] rs2;
	logic [reg_engine_pkg::data_width-1:0]     imm_ext;
	logic [reg_engine_pkg::data_width-1:0]     op_a;
	logic [reg_engine_pkg::data_width-1:0]     op_b;
	logic [reg_engine_pkg::data_width-1:0]     alu_result;
	logic                                      writes_rd;
	logic                                      is_out;
	logic                                      rf_write;

	//////////////////////////////
	// Decode
	//////////////////////////////

	assign opcode = reg_engine_pkg::opcode_e'(
		cmd_data[reg_engine_pkg::opcode_msb:reg_engine_pkg::opcode_lsb]);
	assign rd = cmd_data[reg_engine_pkg::rd_msb:reg_engine_pkg::rd_lsb];
	assign rs1 = cmd_data[reg_engine_pkg::rs1_msb:reg_engine_pkg::rs1_lsb];
	assign rs2 = cmd_data[reg_engine_pkg::rs2_msb:reg_engine_pkg::rs2_lsb];
	assign imm_ext = reg_engine_pkg::data_width'(
		cmd_data[reg_engine_pkg::imm_msb:reg_engine_pkg::imm_lsb]);

	regfile u_regfile (
		.clk           (clk),
		.reset         (reset),
		.write         (rf_write),
		.write_select  (rd),
		.read_select_1 (rs1),
		.read_select_2 (rs2),
		.write_data    (alu_result),
		.read_data_1   (op_a),
		.read_data_2   (op_b)
	);

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		alu_result = '0;
		writes_rd = 1'b0;
		is_out = 1'b0;
		case (opcode)
			reg_engine_pkg::op_add: begin
				alu_result = op_a + op_b;
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_sub: begin
				alu_result = op_a - op_b;
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_and: begin
				alu_result = op_a & op_b;
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_or: begin
				alu_result = op_a | op_b;
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_xor: begin
				alu_result = op_a ^ op_b;
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_shl: begin
				alu_result = op_a << op_b[reg_engine_pkg::shift_width-1:0];
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_shr: begin
				alu_result = op_a >> op_b[reg_engine_pkg::shift_width-1:0];
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_ldi: begin
				alu_result = imm_ext;
				writes_rd = 1'b1;
			end
			reg_engine_pkg::op_out: begin
				is_out = 1'b1;
			end
			// NOP and undefined codes
			default: begin
			end
		endcase
	end

	// OUT holds the head until the result queue has room
	assign res_push_valid = cmd_valid && is_out;
	assign res_push_data = op_a;
	assign cmd_pop = cmd_valid && (!is_out || res_push_ready);
	assign rf_write = cmd_pop && writes_rd;

	// Unpopped head stays at the front of the command queue
	a_head_held: assert property (
		@(posedge clk) disable iff (!reset)
		cmd_valid && !cmd_pop |=> cmd_valid && $stable(cmd_data)
	) else $error("command head changed before exec_unit popped it");

	// Stalled OUT keeps its value while the result queue is full
	a_out_stall_stable: assert property (
		@(posedge clk) disable iff (!reset)
		res_push_valid && !res_push_ready |=> res_push_valid && $stable(res_push_data)
	) else $error("stalled OUT changed before the result queue took it");

endmodule

// ==== reg_engine_top.sv ====
`timescale 1ns/1ps

module reg_engine_top (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic [reg_engine_pkg::axi_addr_width-1:0] awaddr,
	input  logic                                      awvalid,
	output logic                                      awready,
	input  logic [reg_engine_pkg::axi_data_width-1:0] wdata,
	input  logic [reg_engine_pkg::axi_strb_width-1:0] wstrb,
	input  logic                                      wvalid,
	output logic                                      wready,
	output logic [1:0]                                bresp,
	output logic                                      bvalid,
	input  logic                                      bready,
	input  logic [reg_engine_pkg::axi_addr_width-1:0] araddr,
	input  logic                                      arvalid,
	output logic                                      arready,
	output logic [reg_engine_pkg::axi_data_width-1:0] rdata,
	output logic [1:0]                                rresp,
	output logic                                      rvalid,
	input  logic                                      rready
);

	logic                                   cmd_push_valid;
	logic [reg_engine_pkg::instr_width-1:0] cmd_push_data;
	logic                                   cmd_push_ready;
	logic                                   cmd_valid;
	logic [reg_engine_pkg::instr_width-1:0] cmd_data;
	logic                                   cmd_pop;
	logic [reg_engine_pkg::level_width-1:0] cmd_level;
	logic                                   res_push_valid;
	logic [reg_engine_pkg::data_width-1:0]  res_push_data;
	logic                                   res_push_ready;
	logic                                   res_valid;
	logic [reg_engine_pkg::data_width-1:0]  res_data;
	logic                                   res_pop;
	logic [reg_engine_pkg::level_width-1:0] res_level;

	// Host side
	axil_cmd_port u_axil_cmd_port (
		.clk            (clk),
		.reset          (reset),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.awready        (awready),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wvalid         (wvalid),
		.wready         (wready),
		.bresp          (bresp),
		.bvalid         (bvalid),
		.bready         (bready),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arready        (arready),
		.rdata          (rdata),
		.rresp          (rresp),
		.rvalid         (rvalid),
		.rready         (rready),
		.cmd_push_valid (cmd_push_valid),
		.cmd_push_data  (cmd_push_data),
		.cmd_push_ready (cmd_push_ready),
		.res_valid      (res_valid),
		.res_data       (res_data),
		.res_pop        (res_pop),
		.cmd_level      (cmd_level),
		.res_level      (res_level)
	);

	// Instruction queue
	sync_fifo #(
		.width (reg_engine_pkg::instr_width),
		.depth (reg_engine_pkg::cmd_fifo_depth)
	) u_cmd_fifo (
		.clk        (clk),
		.reset      (reset),
		.push_valid (cmd_push_valid),
		.push_data  (cmd_push_data),
		.push_ready (cmd_push_ready),
		.pop_valid  (cmd_valid),
		.pop_data   (cmd_data),
		.pop        (cmd_pop),
		.level      (cmd_level)
	);

	exec_unit u_exec_unit (
		.clk            (clk),
		.reset          (reset),
		.cmd_valid      (cmd_valid),
		.cmd_data       (cmd_data),
		.cmd_pop        (cmd_pop),
		.res_push_valid (res_push_valid),
		.res_push_data  (res_push_data),
		.res_push_ready (res_push_ready)
	);

	// OUT values waiting for the host
	sync_fifo #(
		.width (reg_engine_pkg::data_width),
		.depth (reg_engine_pkg::res_fifo_depth)
	) u_res_fifo (
		.clk        (clk),
		.reset      (reset),
		.push_valid (res_push_valid),
		.push_data  (res_push_data),
		.push_ready (res_push_ready),
		.pop_valid  (res_valid),
		.pop_data   (res_data),
		.pop        (res_pop),
		.level      (res_level)
	);

endmodule

// ==== tb_reg_engine.sv ====
`timescale 1ns/1ps

module tb_reg_engine;

	// Transactions per test are reset 33, ldi_out 24, alu 58, back-pressure 20 and errors 17
	localparam int axi_transactions = 33 + 24 + 58 + 20 + 17;
	localparam int watchdog_cycles = axi_transactions * 40 + 200;

	logic                                      clk;
	logic                                      reset;
	logic [reg_engine_pkg::axi_addr_width-1:0] awaddr;
	logic                                      awvalid;
	logic                                      awready;
	logic [reg_engine_pkg::axi_data_width-1:0] wdata;
	logic [reg_engine_pkg::axi_strb_width-1:0] wstrb;
	logic                                      wvalid;
	logic                                      wready;
	logic [1:0]                                bresp;
	logic                                      bvalid;
	logic                                      bready;
	logic [reg_engine_pkg::axi_addr_width-1:0] araddr;
	logic                                      arvalid;
	logic                                      arready;
	logic [reg_engine_pkg::axi_data_width-1:0] rdata;
	logic [1:0]                                rresp;
	logic                                      rvalid;
	logic                                      rready;

	// Reference register file and the OUT values still owed by the DUT
	logic [15:0] model [16];
	logic [15:0] expected_results [$];
	int          errors;
	integer      seed;

	reg_engine_pkg::opcode_e alu_ops [7] = '{reg_engine_pkg::op_add, reg_engine_pkg::op_sub,
		reg_engine_pkg::op_and, reg_engine_pkg::op_or, reg_engine_pkg::op_xor,
		reg_engine_pkg::op_shl, reg_engine_pkg::op_shr};

	reg_engine_top u_reg_engine_top (
		.clk     (clk),
		.reset   (reset),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// Checks and reference model
	//////////////////////////////

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
			errors++;
		end
	endtask

	function automatic logic [15:0] alu_model(input logic [3:0] op, input logic [15:0] a,
		input logic [15:0] b);
		case (op)
			reg_engine_pkg::op_add: return a + b;
			reg_engine_pkg::op_sub: return a - b;
			reg_engine_pkg::op_and: return a & b;
			reg_engine_pkg::op_or:  return a | b;
			reg_engine_pkg::op_xor: return a ^ b;
			reg_engine_pkg::op_shl: return a << b[3:0];
			default:                return a >> b[3:0];
		endcase
	endfunction

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs1, input logic [3:0] rs2);
		return {op, rd, rs1, rs2};
	endfunction

	//////////////////////////////
	// AXI4-Lite host tasks
	//////////////////////////////

	// Ready pulses are counted at each rising edge until the response shows up
	task automatic axi_write(input string test_name, input logic [3:0] addr,
		input logic [15:0] data, output logic [1:0] resp);
		int either_cycles;
		int both_cycles;
		either_cycles = 0;
		both_cycles = 0;
		@(negedge clk);
		awaddr = addr;
		wdata = {16'ha5a5, data};
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		do begin
			@(posedge clk);
			if (awready || wready) begin
				either_cycles++;
			end
			if (awready && wready) begin
				both_cycles++;
			end
			@(negedge clk);
		end while (!bvalid);
		awvalid = 1'b0;
		wvalid = 1'b0;
		resp = bresp;
		check_value({test_name, " write ready cycles"}, 32'd1, either_cycles);
		check_value({test_name, " awready with wready"}, 32'd1, both_cycles);
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input string test_name, input logic [3:0] addr,
		output logic [31:0] data, output logic [1:0] resp);
		int ready_cycles;
		ready_cycles = 0;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		do begin
			@(posedge clk);
			if (arready) begin
				ready_cycles++;
			end
			@(negedge clk);
		end while (!rvalid);
		arvalid = 1'b0;
		data = rdata;
		resp = rresp;
		check_value({test_name, " arready cycles"}, 32'd1, ready_cycles);
		@(negedge clk);
		rready = 0;
	endtask

	// Sends one instruction and applies it to the model
	task automatic issue(input logic [15:0] instr, input string test_name);
		logic [1:0] resp;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
		op = instr[15:12];
		rd = instr[11:8];
		rs1 = instr[7:4];
		rs2 = instr[3:0];
		axi_write(test_name, reg_engine_pkg::addr_cmd, instr, resp);
		check_value({test_name, " bresp"}, reg_engine_pkg::resp_okay, resp);
		case (op)
			reg_engine_pkg::op_add, reg_engine_pkg::op_sub, reg_engine_pkg::op_and,
			reg_engine_pkg::op_or, reg_engine_pkg::op_xor, reg_engine_pkg::op_shl,
			reg_engine_pkg::op_shr: begin
				model[rd] = alu_model(op, model[rs1], model[rs2]);
			end
			reg_engine_pkg::op_ldi: model[rd] = {8'h00, instr[7:0]};
			reg_engine_pkg::op_out: expected_results.push_back(model[rs1]);
			default: ;
		endcase
	endtask

	task automatic read_result(input string test_name);
		logic [31:0] data;
		logic [1:0]  resp;
		logic [15:0] expected;
		expected = expected_results.pop_front();
		axi_read(test_name, reg_engine_pkg::addr_result, data, resp);
		check_value({test_name, " rresp"}, reg_engine_pkg::resp_okay, resp);
		check_value({test_name, " rdata"}, {16'h0000, expected}, data);
	endtask

	task automatic check_out(input logic [3:0] r, input string test_name);
		issue(encode(reg_engine_pkg::op_out, 4'h0, r, 4'h0), test_name);
		read_result(test_name);
	endtask

	task automatic check_status(input logic [3:0] cmd_lvl, input logic [3:0] res_lvl,
		input string test_name);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(test_name, reg_engine_pkg::addr_status, data, resp);
		check_value({test_name, " rresp"}, reg_engine_pkg::resp_okay, resp);
		check_value({test_name, " status"}, {20'h0, res_lvl, 4'h0, cmd_lvl}, data);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding",
			watchdog_cycles);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [3:0]  rd_sel;
		logic [3:0]  rs2_sel;
		logic [3:0]  prev_rd;
		logic [7:0]  imm;
		logic [31:0] data;
		logic [1:0]  resp;
		clk = 1'b0;
		reset = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		errors = 0;
		seed = 32'hd1a5_8135;
		for (int r = 0; r < 16; r++) begin
			model[r] = 16'h0000;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;

		// Every register reads zero out of reset
		for (int r = 0; r < 16; r++) begin
			check_out(4'(r), "reset_state");
		end
		check_status(4'd0, 4'd0, "idle_status");

		// Immediates come back zero-extended and in order
		for (int i = 0; i < 8; i++) begin
			rd_sel = 4'($random(seed));
			imm = 8'($random(seed));
			issue({reg_engine_pkg::op_ldi, rd_sel, imm}, "ldi_out");
			issue(encode(reg_engine_pkg::op_out, 4'h0, rd_sel, 4'h0), "ldi_out");
		end
		for (int i = 0; i < 8; i++) begin
			read_result("ldi_out");
		end

		// Each op reads the destination of the one before
		for (int r = 0; r < 16; r++) begin
			issue({reg_engine_pkg::op_ldi, 4'(r), 8'($random(seed))}, "alu_preload");
		end
		prev_rd = 4'($random(seed));
		for (int i = 0; i < 14; i++) begin
			rd_sel = 4'($random(seed));
			rs2_sel = 4'($random(seed));
			issue(encode(alu_ops[i % 7], rd_sel, prev_rd, rs2_sel), $sformatf("alu_%0d", i));
			check_out(rd_sel, $sformatf("alu_%0d", i));
			prev_rd = rd_sel;
		end

		// Ninth OUT waits in the command queue behind a full result queue
		for (int i = 0; i < 9; i++) begin
			issue(encode(reg_engine_pkg::op_out, 4'h0, 4'(i), 4'h0), "backpressure");
		end
		check_status(4'd1, 4'd8, "backpressure_full");
		for (int i = 0; i < 9; i++) begin
			read_result($sformatf("backpressure_drain_%0d", i));
		end
		check_status(4'd0, 4'd0, "backpressure_empty");

		//////////////////////////////
		// Error responses
		//////////////////////////////

		axi_write("status_write", reg_engine_pkg::addr_status,
			{reg_engine_pkg::op_ldi, 4'h0, 8'hff}, resp);
		check_value("status_write bresp", reg_engine_pkg::resp_slverr, resp);
		check_status(4'd0, 4'd0, "status_write_no_push");
		check_out(4'h0, "status_write_no_change");
		axi_read("empty_result", reg_engine_pkg::addr_result, data, resp);
		check_value("empty_result rresp", reg_engine_pkg::resp_slverr, resp);
		check_value("empty_result rdata", 32'h0, data);
		for (int op = 0; op < 16; op++) begin
			if (op == 0 || op > 9) begin
				issue({4'(op), 4'h5, 8'h5a}, "nop_undefined");
			end
		end
		check_out(4'h5, "nop_undefined_rd");
		check_out(4'ha, "nop_undefined_rs2");
		check_status(4'd0, 4'd0, "final_idle");

		$display("Finished with %0d errors", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
reg_engine_pkg.sv
regfile.sv
sync_fifo.sv
axil_cmd_port.sv
exec_unit.sv
reg_engine_top.sv
tb_reg_engine.sv

// ==== Bender.yml ====
package:
  name: reg_engine

dependencies: {}

sources:
  - files:
      - reg_engine_pkg.sv
      - regfile.sv
      - sync_fifo.sv
      - axil_cmd_port.sv
      - exec_unit.sv
      - reg_engine_top.sv
  - target: test
    files:
      - tb_reg_engine.sv
